// ==== Bender.yml ====
package:
  name: motor_pool

sources:
  # design, package first
  - rtl/pool_pkg.sv
  - rtl/coef_bank.sv
  - rtl/step_timer.sv
  - rtl/neuron_lane.sv
  - rtl/spike_tally.sv
  - rtl/motor_pool_top.sv
  # testbench
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/motor_pool_props.sv
      - bench/motor_pool_tb.sv

// ==== bench/motor_pool_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_pool_props #(
    parameter int NUM_LANES = 4
) (
    input wire                                     ep50trig,
    input wire                                     reset_global,
    input wire [NUM_LANES-1:0]                     i_spikes,
    input wire [NUM_LANES-1:0][pool_pkg::V_W-1:0]  i_potentials,
    input wire                                     i_counts_valid
);

    // failure count for the testbench summary
    int assert_fails = 0;

    // report is a one-cycle pulse
    assert property (@(posedge ep50trig) disable iff (reset_global)
        i_counts_valid |=> !i_counts_valid)
    else
    begin
        assert_fails++;
        $error("o_counts_valid held high for more than one cycle");
    end

    // lanes stay quiet in reset
    assert property (@(posedge ep50trig) reset_global |-> (i_spikes == '0))
    else
    begin
        assert_fails++;
        $error("o_spikes high during reset");
    end

    // no wrap past the positive limit
    // a non-negative potential turns negative only through a spike
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_limit
        assert property (@(posedge ep50trig) disable iff (reset_global)
            !i_potentials[g][pool_pkg::V_W-1] |=>
                (i_spikes[g] || !i_potentials[g][pool_pkg::V_W-1]))
        else
        begin
            assert_fails++;
            $error("lane %0d potential wrapped past the positive limit", g);
        end
    end

endmodule

bind motor_pool_top motor_pool_props #(
    .NUM_LANES (NUM_LANES)
) u_props (
    .ep50trig       (ep50trig),
    .reset_global   (reset_global),
    .i_spikes       (o_spikes),
    .i_potentials   (o_potentials),
    .i_counts_valid (o_counts_valid)
);

`default_nettype wire

// ==== bench/motor_pool_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_pool_tb;

    localparam int NUM_LANES    = 4;
    localparam int WINDOW_STEPS = 16;
    localparam int V_W          = pool_pkg::V_W;
    localparam int DW           = pool_pkg::DRIVE_W;
    localparam int POS_LIM      = (1 << (V_W - 1)) - 1;
    localparam int NEG_LIM      = -(1 << (V_W - 1));
    localparam int CNT_TOP      = (1 << pool_pkg::COUNT_W) - 1;
    // one window from run to report, step period 3 and 7
    localparam int WIN_P3       = WINDOW_STEPS * 4 + 2;
    localparam int WIN_P7       = WINDOW_STEPS * 8 + 2;
    // two windows at period 3, six at period 7
    localparam int CYCLE_LIMIT  = 2 * (2 * WIN_P3 + 6 * WIN_P7);

    typedef logic [NUM_LANES-1:0][pool_pkg::COUNT_W-1:0] counts_t;
    typedef logic [NUM_LANES-1:0][DW-1:0]                drives_t;

    wire                           ep50trig;
    wire                           reset_global;
    logic                          i_run;
    logic                          i_load;
    pool_pkg::coef_sel_e           i_sel;
    logic [31:0]                   i_data;
    drives_t                       i_drive;
    logic [NUM_LANES-1:0]          o_spikes;
    logic [NUM_LANES-1:0][V_W-1:0] o_potentials;
    counts_t                       o_counts;
    logic                          o_counts_valid;

    // reference state
    pool_pkg::coef_set_t model_coefs;
    pool_pkg::lane_out_t model_lane [NUM_LANES];
    int                  model_cnt  [NUM_LANES];
    int                  model_steps;
    logic                check_pend;
    counts_t             exp_q [$];
    int                  mismatches = 0;
    int                  failures   = 0;
    int                  cycles     = 0;
    integer              seed       = 72;

    tb_clock_gen u_clock_gen (
        .o_clk   (ep50trig),
        .o_reset (reset_global)
    );

    motor_pool_top #(
        .NUM_LANES    (NUM_LANES),
        .WINDOW_STEPS (WINDOW_STEPS)
    ) uut (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_run          (i_run),
        .i_load         (i_load),
        .i_sel          (i_sel),
        .i_data         (i_data),
        .i_drive        (i_drive),
        .o_spikes       (o_spikes),
        .o_potentials   (o_potentials),
        .o_counts       (o_counts),
        .o_counts_valid (o_counts_valid)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // drive times gain, fraction dropped, clamped high
    function automatic int current_ref(input int drive, input int gain);
        longint prod;
        prod = (longint'(drive) * longint'(gain)) >> pool_pkg::GAIN_FRAC;
        if (prod > POS_LIM)
            return POS_LIM;
        return int'(prod);
    endfunction

    // leak, integrate, saturate, fire and reset
    function automatic pool_pkg::lane_out_t lane_ref(input pool_pkg::lane_out_t prev,
                                                     input int cur,
                                                     input pool_pkg::coef_set_t c);
        pool_pkg::lane_out_t nxt;
        int                  pot;
        int                  v;
        int                  thr;
        pot = $signed(prev.potential);
        thr = $signed(c.threshold);
        v   = pot - (pot >>> c.leak_shift) + cur;
        if (v > POS_LIM)
            v = POS_LIM;
        if (v < NEG_LIM)
            v = NEG_LIM;
        nxt.spike     = (v >= thr);
        nxt.potential = nxt.spike ? c.reset_v : v[V_W-1:0];
        return nxt;
    endfunction

    function automatic pool_pkg::lane_out_t lane_got(input int idx);
        pool_pkg::lane_out_t got;
        got.spike     = o_spikes[idx];
        got.potential = o_potentials[idx];
        return got;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_lane(input int idx, input pool_pkg::lane_out_t exp,
                              input pool_pkg::lane_out_t got);
        if (got.spike !== exp.spike)
        begin
            mismatches++;
            $display("Mismatch o_spikes[%0d] cycle %0d: expected %h got %h",
                     idx, cycles, exp.spike, got.spike);
        end
        if (got.potential !== exp.potential)
        begin
            mismatches++;
            $display("Mismatch o_potentials[%0d] cycle %0d: expected %h got %h",
                     idx, cycles, exp.potential, got.potential);
        end
    endtask

    task automatic check_counts(input counts_t exp, input counts_t got);
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (got[i] !== exp[i])
            begin
                mismatches++;
                $display("Mismatch o_counts[%0d] cycle %0d: expected %h got %h",
                         i, cycles, exp[i], got[i]);
            end
        end
    endtask

    // one update per step, checked an edge later when outputs have settled
    always @(posedge ep50trig)
    begin : compare
        counts_t done;
        if (!reset_global)
        begin
            if (check_pend)
            begin
                for (int i = 0; i < NUM_LANES; i++)
                    check_lane(i, model_lane[i], lane_got(i));
                check_pend = 1'b0;
            end
            if (o_counts_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    failures++;
                    $display("report arrived before any window was complete");
                end
                else
                    check_counts(exp_q.pop_front(), o_counts);
            end
            // step strobe used for timing only
            if (uut.u_step_timer.o_step)
            begin
                for (int i = 0; i < NUM_LANES; i++)
                begin
                    model_lane[i] = lane_ref(model_lane[i],
                                             current_ref(i_drive[i], model_coefs.gain),
                                             model_coefs);
                    if (model_lane[i].spike && model_cnt[i] < CNT_TOP)
                        model_cnt[i]++;
                end
                model_steps++;
                check_pend = 1'b1;
                // window closed, queue the counts and start over
                if (model_steps == WINDOW_STEPS)
                begin
                    for (int i = 0; i < NUM_LANES; i++)
                    begin
                        done[i]      = model_cnt[i][pool_pkg::COUNT_W-1:0];
                        model_cnt[i] = 0;
                    end
                    exp_q.push_back(done);
                    model_steps = 0;
                end
            end
        end
    end

    // hang guard
    always @(posedge ep50trig)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, run did not finish", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic load_coef(input pool_pkg::coef_sel_e sel, input logic [31:0] data);
        @(posedge ep50trig);
        i_load <= 1'b1;
        i_sel  <= sel;
        i_data <= data;
        @(posedge ep50trig);
        i_load <= 1'b0;
        // low bits land in the chosen field
        case (sel)
            pool_pkg::sel_gain:        model_coefs.gain        = data[V_W-1:0];
            pool_pkg::sel_threshold:   model_coefs.threshold   = data[V_W-1:0];
            pool_pkg::sel_leak_shift:  model_coefs.leak_shift  = data[3:0];
            pool_pkg::sel_reset_v:     model_coefs.reset_v     = data[V_W-1:0];
            pool_pkg::sel_step_period: model_coefs.step_period = data[15:0];
            default:                   model_coefs             = model_coefs;
        endcase
    endtask

    task automatic set_drives(input drives_t d);
        @(posedge ep50trig);
        i_drive <= d;
    endtask

    // run n windows, latency is edges from run high to first report seen
    task automatic run_windows(input int n, output int latency);
        int seen;
        int edges;
        seen    = 0;
        edges   = 0;
        latency = 0;
        @(posedge ep50trig);
        i_run <= 1'b1;
        while (seen < n)
        begin
            @(posedge ep50trig);
            edges++;
            if (o_counts_valid)
            begin
                if (seen == 0)
                    latency = edges;
                seen++;
            end
        end
        i_run <= 1'b0;
    endtask

    initial
    begin : stimulus
        int      lat;
        int      exp_lat;
        drives_t d;
        i_run   = 1'b0;
        i_load  = 1'b0;
        i_sel   = pool_pkg::sel_gain;
        i_data  = '0;
        i_drive = '0;
        model_coefs = '{gain: 256, threshold: 4096, leak_shift: 3,
                        reset_v: 0, step_period: 3};
        for (int i = 0; i < NUM_LANES; i++)
        begin
            model_lane[i] = '0;
            model_cnt[i]  = 0;
        end
        model_steps = 0;
        check_pend  = 1'b0;
        wait (reset_global === 1'b1);
        wait (reset_global === 1'b0);

        // idle after reset, run low
        repeat (8)
        begin
            @(posedge ep50trig);
            for (int i = 0; i < NUM_LANES; i++)
                check_lane(i, '0, lane_got(i));
        end

        // constant drive per lane, default coefficients
        set_drives({16'd3000, 16'd1500, 16'd700, 16'd500});
        run_windows(1, lat);

        // new gain 1.5, threshold, leak and negative reset value
        load_coef(pool_pkg::sel_gain, 32'd384);
        load_coef(pool_pkg::sel_threshold, 32'd5000);
        load_coef(pool_pkg::sel_leak_shift, 32'd2);
        load_coef(pool_pkg::sel_reset_v, 32'hFFFF_FCE0);
        run_windows(1, lat);

        // slower steps, same drive
        load_coef(pool_pkg::sel_step_period, 32'd7);
        run_windows(1, lat);
        // valid rises 2 cycles after the last step, seen one edge later
        exp_lat = WINDOW_STEPS * (model_coefs.step_period + 1) + 3;
        if (lat != exp_lat)
        begin
            mismatches++;
            $display("Mismatch report latency: expected %h got %h", exp_lat, lat);
        end

        // gain 8.0, threshold at the top of the range
        load_coef(pool_pkg::sel_gain, 32'd2048);
        load_coef(pool_pkg::sel_threshold, 32'h0001_FFFF);
        load_coef(pool_pkg::sel_leak_shift, 32'd4);
        load_coef(pool_pkg::sel_reset_v, 32'd0);
        // clamped, one over, one just under, unclamped
        set_drives({16'hFFFF, 16'h4000, 16'h3FFF, 16'h0100});
        run_windows(1, lat);

        // back to unity gain, random drive per window
        load_coef(pool_pkg::sel_gain, 32'd256);
        load_coef(pool_pkg::sel_threshold, 32'd4096);
        load_coef(pool_pkg::sel_leak_shift, 32'd3);
        for (int w = 0; w < 4; w++)
        begin
            for (int i = 0; i < NUM_LANES; i++)
                d[i] = DW'($random(seed) & 32'h0000_0FFF);
            set_drives(d);
            run_windows(1, lat);
        end

        repeat (4) @(posedge ep50trig);
        if (exp_q.size() != 0)
        begin
            failures++;
            $display("%0d expected reports never arrived", exp_q.size());
        end
        if (uut.u_props.assert_fails != 0)
        begin
            failures += uut.u_props.assert_fails;
            $display("%0d assertion failures", uut.u_props.assert_fails);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_reset
);

    // free running, 40 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // reset edge a little after time zero, released on a rising edge
    initial
    begin
        o_reset = 1'b0;
        #5;
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/pool_pkg.sv
rtl/coef_bank.sv
rtl/step_timer.sv
rtl/neuron_lane.sv
rtl/spike_tally.sv
rtl/motor_pool_top.sv
bench/tb_clock_gen.sv
bench/motor_pool_props.sv
bench/motor_pool_tb.sv

// ==== rtl/coef_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module coef_bank #(
    parameter int NUM_LANES = 4
) (
    input  wire                                             ep50trig,
    input  wire                                             reset_global,
    input  wire                                             i_load,
    input  pool_pkg::coef_sel_e                             i_sel,
    input  wire  [31:0]                                     i_data,
    input  wire  [NUM_LANES-1:0][pool_pkg::DRIVE_W-1:0]     i_drive,
    output pool_pkg::coef_set_t                             o_coefs,
    output logic [NUM_LANES-1:0][pool_pkg::V_W-1:0]         o_current
);

    // full product of drive and gain
    localparam int PROD_W = pool_pkg::DRIVE_W + pool_pkg::V_W;

    logic [NUM_LANES-1:0][pool_pkg::V_W-1:0] current_next;

    ////////////////////////////////////////////////////////////
    // coefficient registers
    ////////////////////////////////////////////////////////////

    // one word per load strobe, low bits into the selected field
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_coefs <= pool_pkg::COEF_RESET;
        end
        else if (i_load)
        begin
            case (i_sel)
                pool_pkg::sel_gain:        o_coefs.gain        <= i_data[pool_pkg::V_W-1:0];
                pool_pkg::sel_threshold:   o_coefs.threshold   <= i_data[pool_pkg::V_W-1:0];
                pool_pkg::sel_leak_shift:  o_coefs.leak_shift  <= i_data[3:0];
                pool_pkg::sel_reset_v:     o_coefs.reset_v     <= i_data[pool_pkg::V_W-1:0];
                pool_pkg::sel_step_period: o_coefs.step_period <= i_data[15:0];
                // unused opcodes leave the set alone
                default:                   o_coefs             <= o_coefs;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // drive scaling
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_scale
        logic [PROD_W-1:0] product;
        logic [PROD_W-1:0] shifted;

        // drive times gain, drop the fraction bits
        assign product = PROD_W'(i_drive[g]) * PROD_W'(o_coefs.gain);
        assign shifted = product >> pool_pkg::GAIN_FRAC;

        // clamp to largest positive potential
        assign current_next[g] = (shifted > PROD_W'(pool_pkg::V_MAX))
                               ? pool_pkg::V_MAX
                               : shifted[pool_pkg::V_W-1:0];
    end

    // one cycle behind drive and gain
    always_ff @(posedge ep50trig)
    begin
        o_current <= current_next;
    end

endmodule

`default_nettype wire

// ==== rtl/motor_pool_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_pool_top #(
    parameter int NUM_LANES    = 4,
    parameter int WINDOW_STEPS = 16
) (
    input  wire                                           ep50trig,
    input  wire                                           reset_global,
    input  wire                                           i_run,
    input  wire                                           i_load,
    input  pool_pkg::coef_sel_e                           i_sel,
    input  wire  [31:0]                                   i_data,
    input  wire  [NUM_LANES-1:0][pool_pkg::DRIVE_W-1:0]   i_drive,
    output logic [NUM_LANES-1:0]                          o_spikes,
    output logic [NUM_LANES-1:0][pool_pkg::V_W-1:0]       o_potentials,
    output logic [NUM_LANES-1:0][pool_pkg::COUNT_W-1:0]   o_counts,
    output logic                                          o_counts_valid
);

    pool_pkg::coef_set_t                     coefs;
    logic [NUM_LANES-1:0][pool_pkg::V_W-1:0] current;
    logic                                    step;
    pool_pkg::lane_out_t                     lane_out [NUM_LANES];

    // host loads and drive scaling
    coef_bank #(
        .NUM_LANES (NUM_LANES)
    ) u_coef_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_load       (i_load),
        .i_sel        (i_sel),
        .i_data       (i_data),
        .i_drive      (i_drive),
        .o_coefs      (coefs),
        .o_current    (current)
    );

    // simulation time step
    step_timer u_step_timer (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_run         (i_run),
        .i_step_period (coefs.step_period),
        .o_step        (step)
    );

    ////////////////////////////////////////////////////////////
    // neuron lanes
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_lane
        neuron_lane u_neuron_lane (
            .ep50trig     (ep50trig),
            .reset_global (reset_global),
            .i_step       (step),
            .i_coefs      (coefs),
            .i_current    (current[g]),
            .o_lane       (lane_out[g])
        );

        // split struct into flat outputs
        assign o_spikes[g]     = lane_out[g].spike;
        assign o_potentials[g] = lane_out[g].potential;
    end

    // windowed spike counts
    spike_tally #(
        .NUM_LANES    (NUM_LANES),
        .WINDOW_STEPS (WINDOW_STEPS)
    ) u_spike_tally (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_step         (step),
        .i_spikes       (o_spikes),
        .o_counts       (o_counts),
        .o_counts_valid (o_counts_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/neuron_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron_lane (
    input  wire                          ep50trig,
    input  wire                          reset_global,
    input  wire                          i_step,
    input  pool_pkg::coef_set_t          i_coefs,
    input  wire  [pool_pkg::V_W-1:0]     i_current,
    output pool_pkg::lane_out_t          o_lane
);

    // two guard bits for leak and current
    localparam int SUM_W = pool_pkg::V_W + 2;

    logic signed [pool_pkg::V_W-1:0] pot_q;
    logic signed [SUM_W-1:0]         leak;
    logic signed [SUM_W-1:0]         sum;
    logic signed [pool_pkg::V_W-1:0] pot_sat;
    logic                            fire;

    ////////////////////////////////////////////////////////////
    // leak and integrate
    ////////////////////////////////////////////////////////////

    assign pot_q = o_lane.potential;

    // arithmetic shift keeps negative potentials decaying toward zero
    assign leak = SUM_W'(pot_q >>> i_coefs.leak_shift);

    // current is never negative after the clamp in coef_bank
    assign sum = SUM_W'(pot_q) - leak + SUM_W'($signed(i_current));

    // clamp at the signed limits
    always_comb
    begin
        if (sum > SUM_W'(pool_pkg::V_MAX))
        begin
            pot_sat = pool_pkg::V_MAX;
        end
        else if (sum < SUM_W'(pool_pkg::V_MIN))
        begin
            pot_sat = pool_pkg::V_MIN;
        end
        else
        begin
            pot_sat = sum[pool_pkg::V_W-1:0];
        end
    end

    // threshold test on the new potential
    assign fire = (pot_sat >= $signed(i_coefs.threshold));

    ////////////////////////////////////////////////////////////
    // state update on the step strobe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_lane <= '0;
        end
        else if (i_step)
        begin
            o_lane.spike <= fire;
            // a spike restarts from the reset value
            if (fire)
            begin
                o_lane.potential <= i_coefs.reset_v;
            end
            else
            begin
                o_lane.potential <= pot_sat;
            end
        end
        else
        begin
            // spike lasts one cycle
            o_lane.spike <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pool_pkg.sv ====
`default_nettype none

package pool_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // potential, current and coefficient values
    localparam int V_W = 18;
    // one lane's drive input
    localparam int DRIVE_W = 16;
    // gain is fixed point, 256 means 1.0
    localparam int GAIN_FRAC = 8;
    // per-lane spike count
    localparam int COUNT_W = 8;

    // signed limits of a potential
    localparam logic signed [V_W-1:0] V_MAX = {1'b0, {(V_W-1){1'b1}}};
    localparam logic signed [V_W-1:0] V_MIN = {1'b1, {(V_W-1){1'b0}}};

    ////////////////////////////////////////////////////////////
    // host load opcode and coefficient set
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        sel_gain        = 3'd0,
        sel_threshold   = 3'd1,
        sel_leak_shift  = 3'd2,
        sel_reset_v     = 3'd3,
        sel_step_period = 3'd4
    } coef_sel_e;

    typedef struct packed {
        logic        [V_W-1:0] gain;
        logic signed [V_W-1:0] threshold;
        logic        [3:0]     leak_shift;
        logic signed [V_W-1:0] reset_v;
        logic        [15:0]    step_period;
    } coef_set_t;

    // values after reset
    localparam coef_set_t COEF_RESET = '{
        gain:        18'd256,
        threshold:   18'sd4096,
        leak_shift:  4'd3,
        reset_v:     18'sd0,
        step_period: 16'd3
    };

    // result of one neuron lane
    typedef struct packed {
        logic                  spike;
        logic signed [V_W-1:0] potential;
    } lane_out_t;

endpackage

`default_nettype wire

// ==== rtl/spike_tally.sv ====
`timescale 1ns/1ps
`default_nettype none

module spike_tally #(
    parameter int NUM_LANES    = 4,
    parameter int WINDOW_STEPS = 16
) (
    input  wire                                           ep50trig,
    input  wire                                           reset_global,
    input  wire                                           i_step,
    input  wire  [NUM_LANES-1:0]                          i_spikes,
    output logic [NUM_LANES-1:0][pool_pkg::COUNT_W-1:0]   o_counts,
    output logic                                          o_counts_valid
);

    // step counter needs at least one bit
    localparam int STEP_W = (WINDOW_STEPS > 1) ? $clog2(WINDOW_STEPS) : 1;
    localparam logic [pool_pkg::COUNT_W-1:0] COUNT_MAX = '1;

    logic [STEP_W-1:0]                             step_cnt;
    logic                                          report_pend;
    logic [NUM_LANES-1:0][pool_pkg::COUNT_W-1:0]   counts;
    logic [NUM_LANES-1:0][pool_pkg::COUNT_W-1:0]   counts_inc;

    ////////////////////////////////////////////////////////////
    // window of steps
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            step_cnt    <= '0;
            report_pend <= 1'b0;
        end
        else
        begin
            report_pend <= 1'b0;
            if (i_step)
            begin
                if (step_cnt == STEP_W'(WINDOW_STEPS - 1))
                begin
                    // last step, report a cycle later once its spikes land
                    step_cnt    <= '0;
                    report_pend <= 1'b1;
                end
                else
                begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // per-lane saturating counters
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_count
        // stick at the top
        assign counts_inc[g] = (i_spikes[g] && (counts[g] != COUNT_MAX))
                             ? counts[g] + 1'b1
                             : counts[g];
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            counts         <= '0;
            o_counts_valid <= 1'b0;
        end
        else
        begin
            o_counts_valid <= report_pend;
            // report cycle starts a fresh window
            if (report_pend)
            begin
                counts <= '0;
            end
            else
            begin
                counts <= counts_inc;
            end
        end
    end

    // report includes the spikes of the final step
    always_ff @(posedge ep50trig)
    begin
        if (report_pend)
        begin
            o_counts <= counts_inc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer (
    input  wire         ep50trig,
    input  wire         reset_global,
    input  wire         i_run,
    input  wire  [15:0] i_step_period,
    output logic        o_step
);

    // counts down from the period, reloads at zero
    logic [15:0] count;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            count  <= '0;
            o_step <= 1'b0;
        end
        else if (!i_run)
        begin
            // stopped, divider parked at zero
            count  <= '0;
            o_step <= 1'b0;
        end
        else
        begin
            if (count == '0)
            begin
                count <= i_step_period;
            end
            else
            begin
                count <= count - 1'b1;
            end
            // strobe on the last count, every cycle for period zero
            o_step <= (count == 16'd1) || (i_step_period == '0);
        end
    end

endmodule

`default_nettype wire
